/* compile.f */
+incdir+logic
logic/axi_pkg.sv
logic/sram_cmd_pkg.sv
logic/axi_sram_wr.sv
logic/axi_sram_rd.sv
logic/sram_port_arbiter.sv
logic/sram_array.sv
logic/axi_sram_bridge.sv
dv/axi_sram_checks.sv
dv/axi_sram_bridge_tb.sv

/* dv/axi_sram_bridge_tb.sv */
`include "sram_bridge_settings.svh"

module axi_sram_bridge_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import axi_pkg::*;

  localparam int CLK_PERIOD     = 8;
  localparam int MAX_BEATS      = 16;
  localparam int N_BURSTS       = 40;
  localparam int TIMEOUT_CYCLES = N_BURSTS * MAX_BEATS * 40 + 1000;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    aw_valid;
  logic    aw_ready;
  axi_aw_t aw;
  logic    w_valid;
  logic    w_ready;
  axi_w_t  w;
  logic    b_valid;
  logic    b_ready;
  axi_b_t  b;
  logic    ar_valid;
  logic    ar_ready;
  axi_ar_t ar;
  logic    r_valid;
  logic    r_ready;
  axi_r_t  r;
  int      data_errors;
  int      resp_errors;
  int      hold_errors;
  int      seed = 32'h6992_f7d2;

  always #(CLK_PERIOD / 2) clk = ~clk;

  axi_sram_bridge axi_sram_bridge_i (.*);

  axi_sram_checks axi_sram_checks_i (.*);

  task automatic send_aw(input axi_aw_t req);
    aw_valid <= 1'b1;
    aw       <= req;
    do begin
      @(posedge clk);
    end while (!aw_ready);
    aw_valid <= 1'b0;
  endtask

  task automatic send_w(input int len, input logic full);
    logic [31:0] rnd;
    for (int k = 0; k <= len; k++) begin
      rnd = $random(seed);
      w_valid <= 1'b1;
      w       <= '{data: rnd[`AXI_DW_BITS-1:0],
                   strb: full ? '1 : rnd[31:32-`AXI_STRB_BITS],
                   last: (k == len)};
      do begin
        @(posedge clk);
      end while (!w_ready);
    end
    w_valid <= 1'b0;
  endtask

  // bready low about a quarter of the time
  task automatic take_b();
    logic [31:0] rnd;
    do begin
      rnd = $random(seed);
      b_ready <= (rnd[1:0] != 2'b00);
      @(posedge clk);
    end while (!(b_valid && b_ready));
    b_ready <= 1'b0;
  endtask

  task automatic write_burst(input logic [`AXI_ID_BITS-1:0] id,
                             input logic [`AXI_AW_BITS-1:0] addr,
                             input int len, input logic aw_first, input logic full);
    fork
      begin
        @(posedge clk);
        if (!aw_first) repeat (3) @(posedge clk);
        send_aw('{id: id, addr: addr, len: len[7:0]});
      end
      begin
        @(posedge clk);
        if (aw_first) repeat (2) @(posedge clk);
        send_w(len, full);
      end
    join
    take_b();
  endtask

  task automatic read_burst(input logic [`AXI_ID_BITS-1:0] id,
                            input logic [`AXI_AW_BITS-1:0] addr, input int len);
    logic [31:0] rnd;
    int          beats;
    ar_valid <= 1'b1;
    ar       <= '{id: id, addr: addr, len: len[7:0]};
    do begin
      @(posedge clk);
    end while (!ar_ready);
    ar_valid <= 1'b0;
    beats = 0;
    while (beats <= len) begin
      rnd = $random(seed);
      r_ready <= (rnd[1:0] != 2'b00);
      @(posedge clk);
      if (r_valid && r_ready) beats++;
    end
    r_ready <= 1'b0;
  endtask

  initial begin
    logic [`AXI_AW_BITS-1:0] base;
    logic [31:0]             rnd;
    int                      len;
    rst_n    = 1'b0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar       = '0;
    r_ready  = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Single beats, AW first then W first
    write_burst(4'h1, 20'h00100, 0, 1'b1, 1'b1);
    write_burst(4'h2, 20'h00102, 0, 1'b0, 1'b1);
    read_burst(4'h3, 20'h00100, 0);
    read_burst(4'h4, 20'h00100, 1);

    // Full bursts, then partial strobes over the same words
    for (int i = 0; i < 6; i++) begin
      rnd  = $random(seed);
      len  = int'(rnd[7:4]);
      base = 20'h01000 + 20'(i * 64);
      write_burst(rnd[3:0], base, len, (i % 2 == 0), 1'b1);
      read_burst(rnd[11:8], base, len);
      write_burst(rnd[15:12], base, len, (i % 2 != 0), 1'b0);
      read_burst(rnd[19:16], base, len);
    end

    // Reads and writes together on disjoint ranges
    for (int i = 0; i < 3; i++) begin
      rnd = $random(seed);
      write_burst(rnd[3:0], 20'h04000 + 20'(i * 64), MAX_BEATS - 1, 1'b1, 1'b1);
      fork
        write_burst(rnd[7:4], 20'h08000 + 20'(i * 64), MAX_BEATS - 1, (i != 1), 1'b1);
        read_burst(rnd[11:8], 20'h04000 + 20'(i * 64), MAX_BEATS - 1);
      join
      read_burst(rnd[15:12], 20'h08000 + 20'(i * 64), MAX_BEATS - 1);
    end

    repeat (4) @(posedge clk);
    $display("Errors: data %0d, response %0d, hold %0d", data_errors, resp_errors, hold_errors);
    if (data_errors + resp_errors + hold_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: bursts did not complete within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* dv/axi_sram_checks.sv */
`include "sram_bridge_settings.svh"

module axi_sram_checks (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             aw_valid,
  input  logic             aw_ready,
  input  axi_pkg::axi_aw_t aw,
  input  logic             w_valid,
  input  logic             w_ready,
  input  axi_pkg::axi_w_t  w,
  input  logic             b_valid,
  input  logic             b_ready,
  input  axi_pkg::axi_b_t  b,
  input  logic             ar_valid,
  input  logic             ar_ready,
  input  axi_pkg::axi_ar_t ar,
  input  logic             r_valid,
  input  logic             r_ready,
  input  axi_pkg::axi_r_t  r,
  output int               data_errors,
  output int               resp_errors,
  output int               hold_errors
);
  timeunit 1ns;
  timeprecision 100ps;
  import axi_pkg::*;

  localparam int STRB = `AXI_STRB_BITS;

  // Byte-wise reference memory, keyed by byte address
  logic [7:0]              ref_mem [int];
  logic [`AXI_ID_BITS-1:0] b_ids [$];
  axi_ar_t                 reads [$];
  int                      wr_word;
  int                      rd_beat;
  int                      data_err_cnt = 0;
  int                      resp_err_cnt = 0;
  int                      hold_err_cnt = 0;

  // Expectations for the current cycle, set on the previous edge
  logic                    b_expected;
  logic                    r_expected;
  logic [`AXI_ID_BITS-1:0] exp_b_id;
  logic [`AXI_ID_BITS-1:0] exp_r_id;
  logic [`AXI_DW_BITS-1:0] exp_r_data;
  logic                    exp_r_last;

  assign data_errors = data_err_cnt;
  assign resp_errors = resp_err_cnt;
  assign hold_errors = hold_err_cnt;

  // Unwritten bytes come back as X and fail the compare
  function automatic logic [`AXI_DW_BITS-1:0] ref_word(int word);
    logic [`AXI_DW_BITS-1:0] value;
    for (int i = 0; i < STRB; i++) begin
      value[i*8 +: 8] = ref_mem.exists(word * STRB + i) ? ref_mem[word * STRB + i] : 8'hxx;
    end
    return value;
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      b_ids.delete();
      reads.delete();
      rd_beat = 0;
      b_expected <= 1'b0;
      r_expected <= 1'b0;
    end else begin
      if (aw_valid && aw_ready) begin
        b_ids.push_back(aw.id);
        wr_word = aw.addr / STRB;
      end
      if (w_valid && w_ready) begin
        for (int i = 0; i < STRB; i++) begin
          if (w.strb[i]) begin
            ref_mem[wr_word * STRB + i] = w.data[i*8 +: 8];
          end
        end
        wr_word++;
      end
      if (b_valid && b_ready && b_ids.size() != 0) begin
        void'(b_ids.pop_front());
      end
      if (ar_valid && ar_ready) begin
        reads.push_back(ar);
      end
      if (r_valid && r_ready && reads.size() != 0) begin
        if (rd_beat == int'(reads[0].len)) begin
          void'(reads.pop_front());
          rd_beat = 0;
        end else begin
          rd_beat++;
        end
      end
      b_expected <= (b_ids.size() != 0);
      if (b_ids.size() != 0) begin
        exp_b_id <= b_ids[0];
      end
      r_expected <= (reads.size() != 0);
      if (reads.size() != 0) begin
        exp_r_id   <= reads[0].id;
        exp_r_data <= ref_word(reads[0].addr / STRB + rd_beat);
        exp_r_last <= (rd_beat == int'(reads[0].len));
      end
    end
  end

  reset_idle: assert property (
    @(posedge clk) $rose(rst_n) |-> (!b_valid && !r_valid)
  ) else begin
    resp_err_cnt++;
    $display("FAILED %0t: response valid in the cycle after reset", $time);
  end

  b_fields: assert property (
    @(posedge clk) disable iff (!rst_n)
    b_valid |-> (b_expected && b.id == exp_b_id && b.resp == AXI_RESP_OKAY)
  ) else begin
    resp_err_cnt++;
    $display("FAILED %0t: B id %0h resp %0d, expected id %0h", $time, b.id, b.resp, exp_b_id);
  end

  r_fields: assert property (
    @(posedge clk) disable iff (!rst_n)
    r_valid |-> (r_expected && r.id == exp_r_id && r.resp == AXI_RESP_OKAY
                 && r.last == exp_r_last)
  ) else begin
    resp_err_cnt++;
    $display("FAILED %0t: R id %0h last %0b, expected id %0h last %0b",
             $time, r.id, r.last, exp_r_id, exp_r_last);
  end

  r_data: assert property (
    @(posedge clk) disable iff (!rst_n)
    r_valid |-> (r.data == exp_r_data)
  ) else begin
    data_err_cnt++;
    $display("FAILED %0t: R data %h, expected %h", $time, r.data, exp_r_data);
  end

  b_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (b_valid && !b_ready) |=> (b_valid && $stable(b))
  ) else begin
    hold_err_cnt++;
    $display("FAILED %0t: B changed while stalled", $time);
  end

  r_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (r_valid && !r_ready) |=> (r_valid && $stable(r))
  ) else begin
    hold_err_cnt++;
    $display("FAILED %0t: R changed while stalled", $time);
  end

endmodule

/* logic/axi_pkg.sv */
`include "sram_bridge_settings.svh"

package axi_pkg;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // INCR only, full width beats, so no burst or size field
  typedef struct packed {
    logic [`AXI_ID_BITS-1:0] id;
    logic [`AXI_AW_BITS-1:0] addr;
    logic [7:0]              len;
  } axi_aw_t;

  typedef struct packed {
    logic [`AXI_DW_BITS-1:0]   data;
    logic [`AXI_STRB_BITS-1:0] strb;
    logic                      last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0] id;
    logic [1:0]              resp;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0] id;
    logic [`AXI_AW_BITS-1:0] addr;
    logic [7:0]              len;
  } axi_ar_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0] id;
    logic [`AXI_DW_BITS-1:0] data;
    logic [1:0]              resp;
    logic                    last;
  } axi_r_t;

endpackage

/* logic/axi_sram_bridge.sv */
`include "sram_bridge_settings.svh"

module axi_sram_bridge (
  input  logic             clk,
  input  logic             rst_n,

  input  logic             aw_valid,
  output logic             aw_ready,
  input  axi_pkg::axi_aw_t aw,

  input  logic             w_valid,
  output logic             w_ready,
  input  axi_pkg::axi_w_t  w,

  output logic             b_valid,
  input  logic             b_ready,
  output axi_pkg::axi_b_t  b,

  input  logic             ar_valid,
  output logic             ar_ready,
  input  axi_pkg::axi_ar_t ar,

  output logic             r_valid,
  input  logic             r_ready,
  output axi_pkg::axi_r_t  r
);
  import sram_cmd_pkg::*;

  logic                      wr_cmd_valid;
  logic                      wr_cmd_ready;
  sram_wr_cmd_t              wr_cmd;
  logic                      rd_cmd_valid;
  logic                      rd_cmd_ready;
  sram_rd_cmd_t              rd_cmd;

  logic                      mem_en;
  logic                      mem_we;
  logic [`SRAM_AW_BITS-1:0]  mem_addr;
  logic [`AXI_DW_BITS-1:0]   mem_wdata;
  logic [`AXI_STRB_BITS-1:0] mem_strb;
  logic [`AXI_DW_BITS-1:0]   mem_rdata;

  axi_sram_wr axi_sram_wr_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .aw           (aw),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .w            (w),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .b            (b),
    .wr_cmd_valid (wr_cmd_valid),
    .wr_cmd_ready (wr_cmd_ready),
    .wr_cmd       (wr_cmd)
  );

  axi_sram_rd axi_sram_rd_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .ar           (ar),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .r            (r),
    .rd_cmd_valid (rd_cmd_valid),
    .rd_cmd_ready (rd_cmd_ready),
    .rd_cmd       (rd_cmd),
    .rd_data      (mem_rdata)
  );

  sram_port_arbiter sram_port_arbiter_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_cmd_valid (wr_cmd_valid),
    .wr_cmd_ready (wr_cmd_ready),
    .wr_cmd       (wr_cmd),
    .rd_cmd_valid (rd_cmd_valid),
    .rd_cmd_ready (rd_cmd_ready),
    .rd_cmd       (rd_cmd),
    .mem_en       (mem_en),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_strb     (mem_strb)
  );

  sram_array sram_array_i (
    .clk       (clk),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_strb  (mem_strb),
    .mem_rdata (mem_rdata)
  );

endmodule

/* logic/axi_sram_rd.sv */
`include "sram_bridge_settings.svh"

module axi_sram_rd (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       ar_valid,
  output logic                       ar_ready,
  input  axi_pkg::axi_ar_t           ar,

  output logic                       r_valid,
  input  logic                       r_ready,
  output axi_pkg::axi_r_t            r,

  output logic                       rd_cmd_valid,
  input  logic                       rd_cmd_ready,
  output sram_cmd_pkg::sram_rd_cmd_t rd_cmd,

  input  logic [`AXI_DW_BITS-1:0]    rd_data
);
  import axi_pkg::*;

  logic                     burst_active;
  logic                     in_flight;
  logic [`AXI_ID_BITS-1:0]  id_q;
  logic [`SRAM_AW_BITS-1:0] addr_q;
  logic [8:0]               issue_left;
  logic [7:0]               ret_left;
  logic                     ar_fire;
  logic                     r_fire;
  logic                     r_free;
  logic                     cmd_fire;

  assign ar_fire  = ar_valid && ar_ready;
  assign r_fire   = r_valid && r_ready;
  assign cmd_fire = rd_cmd_valid && rd_cmd_ready;

  // R register is empty next cycle
  assign r_free = !r_valid || r_ready;

  // One read in flight at most, and only into a free R register
  assign rd_cmd_valid = burst_active && (issue_left != 9'd0) && !in_flight && r_free;
  assign rd_cmd       = '{addr: addr_q};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ar_ready     <= 1'b0;
      burst_active <= 1'b0;
      in_flight    <= 1'b0;
      r_valid      <= 1'b0;
    end else begin
      if (ar_fire) begin
        ar_ready <= 1'b0;
      end else if (!burst_active || (r_fire && r.last)) begin
        ar_ready <= 1'b1;
      end

      if (ar_fire) begin
        burst_active <= 1'b1;
      end else if (r_fire && r.last) begin
        burst_active <= 1'b0;
      end

      in_flight <= cmd_fire;

      if (in_flight) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q       <= ar.id;
      addr_q     <= ar.addr[`AXI_AW_BITS-1:`AXI_AW_BITS-`SRAM_AW_BITS];
      issue_left <= {1'b0, ar.len} + 9'd1;
    end else if (cmd_fire) begin
      addr_q     <= addr_q + 1'b1;
      issue_left <= issue_left - 1'b1;
    end
  end

  // Array data lands here one cycle after the command
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      ret_left <= ar.len;
    end else if (in_flight) begin
      ret_left <= ret_left - 1'b1;
    end
    if (in_flight) begin
      r <= '{id: id_q, data: rd_data, resp: AXI_RESP_OKAY, last: (ret_left == 8'd0)};
    end
  end

  r_no_overwrite: assert property (
    @(posedge clk) disable iff (!rst_n)
    (r_valid && !r_ready) |-> !in_flight
  ) else $error("read data returned into a stalled R register");

endmodule

/* logic/axi_sram_wr.sv */
`include "sram_bridge_settings.svh"

module axi_sram_wr (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       aw_valid,
  output logic                       aw_ready,
  input  axi_pkg::axi_aw_t           aw,

  input  logic                       w_valid,
  output logic                       w_ready,
  input  axi_pkg::axi_w_t            w,

  output logic                       b_valid,
  input  logic                       b_ready,
  output axi_pkg::axi_b_t            b,

  output logic                       wr_cmd_valid,
  input  logic                       wr_cmd_ready,
  output sram_cmd_pkg::sram_wr_cmd_t wr_cmd
);
  import axi_pkg::*;

  logic                     burst_active;
  logic [`AXI_ID_BITS-1:0]  id_q;
  logic [`SRAM_AW_BITS-1:0] addr_q;
  logic [7:0]               beats_left;
  logic                     aw_fire;
  logic                     w_fire;
  logic                     last_beat;
  logic                     beat_open;

  assign aw_fire   = aw_valid && aw_ready;
  assign w_fire    = w_valid && w_ready;
  assign last_beat = (beats_left == 8'd0);

  // W is held off until AW is latched and while B waits
  assign beat_open = burst_active && !b_valid;

  // Beats go straight to the SRAM port
  assign wr_cmd_valid = beat_open && w_valid;
  assign w_ready      = beat_open && wr_cmd_ready;
  assign wr_cmd       = '{addr: addr_q, data: w.data, strb: w.strb};

  assign b = '{id: id_q, resp: AXI_RESP_OKAY};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_ready     <= 1'b0;
      burst_active <= 1'b0;
      b_valid      <= 1'b0;
    end else begin
      // Reopen AW only once the previous B has gone out
      if (aw_fire) begin
        aw_ready <= 1'b0;
      end else if (!burst_active && (!b_valid || b_ready)) begin
        aw_ready <= 1'b1;
      end

      if (aw_fire) begin
        burst_active <= 1'b1;
      end else if (w_fire && last_beat) begin
        burst_active <= 1'b0;
      end

      if (w_fire && last_beat) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  // Burst state
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q       <= aw.id;
      addr_q     <= aw.addr[`AXI_AW_BITS-1:`AXI_AW_BITS-`SRAM_AW_BITS];
      beats_left <= aw.len;
    end else if (w_fire) begin
      addr_q     <= addr_q + 1'b1;
      beats_left <= beats_left - 1'b1;
    end
  end

  wlast_matches_len: assert property (
    @(posedge clk) disable iff (!rst_n)
    w_fire |-> (w.last == last_beat)
  ) else $error("wlast disagrees with the burst length");

endmodule

/* logic/sram_array.sv */
`include "sram_bridge_settings.svh"

module sram_array (
  input  logic                      clk,
  input  logic                      mem_en,
  input  logic                      mem_we,
  input  logic [`SRAM_AW_BITS-1:0]  mem_addr,
  input  logic [`AXI_DW_BITS-1:0]   mem_wdata,
  input  logic [`AXI_STRB_BITS-1:0] mem_strb,
  output logic [`AXI_DW_BITS-1:0]   mem_rdata
);

  logic [`AXI_DW_BITS-1:0] mem [`SRAM_DEPTH];

  // Byte lanes written only where the strobe is set
  always_ff @(posedge clk) begin
    if (mem_en && mem_we) begin
      for (int i = 0; i < `AXI_STRB_BITS; i++) begin
        if (mem_strb[i]) begin
          mem[mem_addr][i*8 +: 8] <= mem_wdata[i*8 +: 8];
        end
      end
    end
  end

  // One cycle read latency, output holds between reads
  always_ff @(posedge clk) begin
    if (mem_en && !mem_we) begin
      mem_rdata <= mem[mem_addr];
    end
  end

endmodule

/* logic/sram_bridge_settings.svh */
`ifndef SRAM_BRIDGE_SETTINGS_SVH
`define SRAM_BRIDGE_SETTINGS_SVH

// AXI bus widths
`define AXI_AW_BITS 20
`define AXI_DW_BITS 16
`define AXI_ID_BITS 4
`define AXI_STRB_BITS (`AXI_DW_BITS / 8)

// Word addressed SRAM behind the bus
`define SRAM_AW_BITS (`AXI_AW_BITS - $clog2(`AXI_STRB_BITS))
`define SRAM_DEPTH (1 << `SRAM_AW_BITS)

`endif

/* logic/sram_cmd_pkg.sv */
`include "sram_bridge_settings.svh"

package sram_cmd_pkg;

  // Memory side command words, one per SRAM access
  typedef struct packed {
    logic [`SRAM_AW_BITS-1:0]  addr;
    logic [`AXI_DW_BITS-1:0]   data;
    logic [`AXI_STRB_BITS-1:0] strb;
  } sram_wr_cmd_t;

  // Read data comes back a cycle later on its own bus
  typedef struct packed {
    logic [`SRAM_AW_BITS-1:0] addr;
  } sram_rd_cmd_t;

endpackage

/* logic/sram_port_arbiter.sv */
`include "sram_bridge_settings.svh"

module sram_port_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       wr_cmd_valid,
  output logic                       wr_cmd_ready,
  input  sram_cmd_pkg::sram_wr_cmd_t wr_cmd,

  input  logic                       rd_cmd_valid,
  output logic                       rd_cmd_ready,
  input  sram_cmd_pkg::sram_rd_cmd_t rd_cmd,

  output logic                       mem_en,
  output logic                       mem_we,
  output logic [`SRAM_AW_BITS-1:0]   mem_addr,
  output logic [`AXI_DW_BITS-1:0]    mem_wdata,
  output logic [`AXI_STRB_BITS-1:0]  mem_strb
);

  logic last_wr;
  logic grant_wr;
  logic grant_rd;

  // On a tie the side that lost last time goes first
  assign grant_wr = wr_cmd_valid && (!rd_cmd_valid || !last_wr);
  assign grant_rd = rd_cmd_valid && !grant_wr;

  assign wr_cmd_ready = grant_wr;
  assign rd_cmd_ready = grant_rd;

  assign mem_en    = grant_wr || grant_rd;
  assign mem_we    = grant_wr;
  assign mem_addr  = grant_wr ? wr_cmd.addr : rd_cmd.addr;
  assign mem_wdata = wr_cmd.data;
  assign mem_strb  = wr_cmd.strb;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_wr <= 1'b0;
    end else if (grant_wr) begin
      last_wr <= 1'b1;
    end else if (grant_rd) begin
      last_wr <= 1'b0;
    end
  end

  // A read that lost a tie holds valid and must win the next cycle
  rd_after_tie: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wr_cmd_valid && rd_cmd_valid && wr_cmd_ready) |=> rd_cmd_ready
  ) else $error("read starved after losing arbitration");

endmodule
